//--- portalBusPkg.sv
`default_nettype none

package portalBusPkg;

  typedef logic [31:0] dataWord_t;

  // Bit 12 picks the portal, bits 11:5 the page, bits 4:0 the byte offset
  typedef logic [12:0] busAddr_t;
  typedef logic [4:0]  portalOffset_t;
  typedef logic [3:0]  burstLen_t;   // Beats minus one
  typedef logic [5:0]  txnId_t;

  typedef struct packed {
    busAddr_t  addr;
    burstLen_t len;
    txnId_t    id;
  } burstReq_t;

  typedef struct packed {
    logic          indication;   // 1 for the indication portal
    logic          control;      // Page zero
    portalOffset_t offset;
    txnId_t        id;
    logic          last;
    logic          write;
    dataWord_t     data;
  } beat_t;

  typedef struct packed {
    dataWord_t data;
    txnId_t    id;
    logic      last;
  } readResp_t;

  localparam int BEAT_BYTES  = 4;
  localparam int QUEUE_DEPTH = 2;

endpackage

`default_nettype wire

//--- portalRegPkg.sv
`default_nettype none

package portalRegPkg;

  // Control page
  localparam logic [4:0] REG_INTR_STATUS  = 5'h00;
  localparam logic [4:0] REG_INTR_ENABLE  = 5'h04;
  localparam logic [4:0] REG_NUM_TILES    = 5'h08;
  localparam logic [4:0] REG_QUEUE_STATUS = 5'h0C;
  localparam logic [4:0] REG_PORTAL_ID    = 5'h10;
  localparam logic [4:0] REG_NUM_PORTALS  = 5'h14;

  // Data pages
  localparam logic [4:0] DATA_WORD  = 5'h00;
  localparam logic [4:0] DATA_SPACE = 5'h04;

  localparam logic [31:0] NUM_TILES            = 32'd1;
  localparam logic [31:0] NUM_PORTALS          = 32'd2;
  localparam logic [31:0] REQUEST_PORTAL_ID    = 32'd5;
  localparam logic [31:0] INDICATION_PORTAL_ID = 32'd6;
  localparam logic [31:0] UNMAPPED_VALUE       = 32'h005A05A0;

endpackage

`default_nettype wire

//--- burstSplitter.sv
`timescale 1ns/1ps
`default_nettype none

module burstSplitter (
  input  logic                    CLK,
  input  logic                    nRST,
  input  portalBusPkg::burstReq_t req,
  input  logic                    reqValid,
  output logic                    reqReady,
  output portalBusPkg::beat_t     beat,
  output logic                    beatValid,
  input  logic                    beatReady,
  input  portalBusPkg::dataWord_t data,
  input  logic                    dataValid,
  output logic                    dataReady,
  input  logic                    isWrite
);
  import portalBusPkg::*;

  logic          first;          // Next beat opens a burst
  portalOffset_t offset;
  burstLen_t     remaining;
  portalOffset_t curOffset;
  burstLen_t     curRemaining;
  logic          fire;

  assign curOffset    = first ? req.addr[4:0] : offset;
  assign curRemaining = first ? req.len : remaining;

  always_comb begin
    beat.indication = req.addr[12];
    beat.control    = req.addr[11:5] == 7'd0;
    beat.offset     = curOffset;
    beat.id         = req.id;
    beat.last       = curRemaining == '0;
    beat.write      = isWrite;
    beat.data       = data;
  end

  // One data word per beat, the read side ties dataValid high
  assign beatValid = reqValid && dataValid;
  assign dataReady = reqValid && beatReady;
  assign fire      = beatValid && beatReady;
  assign reqReady  = fire && beat.last;   // Pop the burst after its final beat

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      first     <= 1'b1;
      offset    <= '0;
      remaining <= '0;
    end else if (fire) begin
      first     <= beat.last;
      offset    <= curOffset + portalOffset_t'(BEAT_BYTES);   // Wraps in 32 bytes
      remaining <= curRemaining - 1'b1;
    end
  end

  // Mid-burst the request stays queued and the count never wraps past its length
  assert property (@(posedge CLK) disable iff (!nRST)
    !first |-> reqValid && remaining < req.len);

endmodule

`default_nettype wire

//--- readChannel.sv
`timescale 1ns/1ps
`default_nettype none

module readChannel (
  input  logic                    CLK,
  input  logic                    nRST,
  input  portalBusPkg::burstReq_t arReq,
  input  logic                    arValid,
  output logic                    arReady,
  output portalBusPkg::readResp_t r,
  output logic                    rValid,
  input  logic                    rReady,
  output portalBusPkg::beat_t     beat,
  output logic                    beatValid,
  input  logic                    beatReady,
  input  portalBusPkg::dataWord_t regData
);
  import portalBusPkg::*;

  burstReq_t  arMem [QUEUE_DEPTH];
  readResp_t  rMem [QUEUE_DEPTH];
  logic       arWrPtr, arRdPtr, rWrPtr, rRdPtr;
  logic [1:0] arCount, rCount;
  logic       arPush, arPop, rPush, rPop;
  logic       splitValid;
  logic       space;     // Read-data queue can take a beat

  assign arReady   = arCount != 2'(QUEUE_DEPTH);
  assign arPush    = arValid && arReady;
  assign space     = rCount != 2'(QUEUE_DEPTH);
  assign beatValid = splitValid && space;
  assign rPush     = beatValid && beatReady;
  assign rValid    = rCount != '0;
  assign rPop      = rValid && rReady;
  assign r         = rMem[rRdPtr];

  burstSplitter splitter (
    .CLK, .nRST,
    .req(arMem[arRdPtr]), .reqValid(arCount != '0), .reqReady(arPop),
    .beat, .beatValid(splitValid), .beatReady(beatReady && space),
    .data('0), .dataValid(1'b1), .dataReady(), .isWrite(1'b0)
  );

  always_ff @(posedge CLK) begin
    if (arPush)
      arMem[arWrPtr] <= arReq;
    if (rPush)
      rMem[rWrPtr] <= '{data: regData, id: beat.id, last: beat.last};
  end

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      arWrPtr <= 1'b0;
      arRdPtr <= 1'b0;
      rWrPtr  <= 1'b0;
      rRdPtr  <= 1'b0;
      arCount <= '0;
      rCount  <= '0;
    end else begin
      if (arPush)
        arWrPtr <= !arWrPtr;
      if (arPop)
        arRdPtr <= !arRdPtr;
      if (rPush)
        rWrPtr <= !rWrPtr;
      if (rPop)
        rRdPtr <= !rRdPtr;
      arCount <= arCount + 2'(arPush) - 2'(arPop);
      rCount  <= rCount + 2'(rPush) - 2'(rPop);
    end
  end

endmodule

`default_nettype wire

//--- writeChannel.sv
`timescale 1ns/1ps
`default_nettype none

module writeChannel (
  input  logic                    CLK,
  input  logic                    nRST,
  input  portalBusPkg::burstReq_t awReq,
  input  logic                    awValid,
  output logic                    awReady,
  input  portalBusPkg::dataWord_t wData,
  input  logic                    wLast,
  input  logic                    wValid,
  output logic                    wReady,
  output portalBusPkg::txnId_t    bId,
  output logic                    bValid,
  input  logic                    bReady,
  output portalBusPkg::beat_t     beat,
  output logic                    beatValid,
  input  logic                    beatReady
);
  import portalBusPkg::*;

  burstReq_t  awMem [QUEUE_DEPTH];
  dataWord_t  wMem [QUEUE_DEPTH];
  logic       awWrPtr, awRdPtr, wWrPtr, wRdPtr;
  logic [1:0] awCount, wCount;
  logic       awPush, awPop, wPush, wPop;
  logic       lastSeen;     // Burst data complete, wait for the next address
  logic       splitValid;
  logic       stallLast;
  logic       respPush;
  logic       respValid;
  txnId_t     respId;

  assign awReady = awCount != 2'(QUEUE_DEPTH);
  assign awPush  = awValid && awReady;
  assign wReady  = !lastSeen && wCount != 2'(QUEUE_DEPTH);
  assign wPush   = wValid && wReady;

  // Final beat waits until the response slot is free
  assign stallLast = beat.last && respValid;
  assign beatValid = splitValid && !stallLast;
  assign respPush  = beatValid && beatReady && beat.last;
  assign bValid    = respValid;
  assign bId       = respId;

  burstSplitter splitter (
    .CLK, .nRST,
    .req(awMem[awRdPtr]), .reqValid(awCount != '0), .reqReady(awPop),
    .beat, .beatValid(splitValid), .beatReady(beatReady && !stallLast),
    .data(wMem[wRdPtr]), .dataValid(wCount != '0), .dataReady(wPop), .isWrite(1'b1)
  );

  always_ff @(posedge CLK) begin
    if (awPush)
      awMem[awWrPtr] <= awReq;
    if (wPush)
      wMem[wWrPtr] <= wData;
    if (respPush)
      respId <= beat.id;
  end

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      awWrPtr   <= 1'b0;
      awRdPtr   <= 1'b0;
      wWrPtr    <= 1'b0;
      wRdPtr    <= 1'b0;
      awCount   <= '0;
      wCount    <= '0;
      lastSeen  <= 1'b0;
      respValid <= 1'b0;
    end else begin
      if (awPush)
        awWrPtr <= !awWrPtr;
      if (awPop)
        awRdPtr <= !awRdPtr;
      if (wPush)
        wWrPtr <= !wWrPtr;
      if (wPop)
        wRdPtr <= !wRdPtr;
      awCount <= awCount + 2'(awPush) - 2'(awPop);
      wCount  <= wCount + 2'(wPush) - 2'(wPop);
      if (awPush || (wPush && wLast))
        lastSeen <= !awPush;   // A new address wins
      if (respPush)
        respValid <= 1'b1;
      else if (bValid && bReady)
        respValid <= 1'b0;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST) respPush |-> !respValid);

endmodule

`default_nettype wire

//--- beatArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module beatArbiter (
  input  logic                CLK,
  input  logic                nRST,
  input  portalBusPkg::beat_t rdBeat,
  input  logic                rdValid,
  output logic                rdReady,
  input  portalBusPkg::beat_t wrBeat,
  input  logic                wrValid,
  output logic                wrReady,
  output portalBusPkg::beat_t port,
  output logic                portValid,
  input  logic                portReady
);
  import portalBusPkg::*;

  logic  writeFirst;   // Flips after every transfer
  logic  rdGrant;
  logic  wrGrant;
  beat_t granted;

  assign rdGrant = rdValid && (!wrValid || !writeFirst);
  assign wrGrant = wrValid && (!rdValid || writeFirst);

  assign granted   = wrGrant ? wrBeat : rdBeat;
  assign port      = granted;
  assign portValid = rdValid || wrValid;
  assign rdReady   = rdGrant && portReady;
  assign wrReady   = wrGrant && portReady;

  always_ff @(posedge CLK) begin
    if (!nRST)
      writeFirst <= 1'b0;
    else if (portValid && portReady)
      writeFirst <= !writeFirst;
  end

  assert property (@(posedge CLK) disable iff (!nRST) !(rdReady && wrReady));

endmodule

`default_nettype wire

//--- portalRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module portalRegisters (
  input  logic                    CLK,
  input  logic                    nRST,
  input  portalBusPkg::beat_t     port,
  input  logic                    portValid,
  output logic                    portReady,
  output portalBusPkg::dataWord_t portRead,
  output portalBusPkg::dataWord_t requestWord,
  output logic                    requestValid,
  input  logic                    requestReady,
  input  portalBusPkg::dataWord_t indicationWord,
  input  logic                    indicationValid,
  output logic                    indicationReady,
  output logic                    interrupt
);
  import portalBusPkg::*;
  import portalRegPkg::*;

  logic      intrEnable;
  logic      pending;       // Only visible through the indication portal
  logic      dataWordHit;
  dataWord_t ctrlRead;
  dataWord_t dataRead;

  assign pending     = port.indication && indicationValid;
  assign dataWordHit = !port.control && port.offset == DATA_WORD;

  always_comb begin
    case (port.offset)
      REG_INTR_STATUS,
      REG_QUEUE_STATUS: ctrlRead = {31'd0, pending};
      REG_INTR_ENABLE:  ctrlRead = {31'd0, intrEnable};
      REG_NUM_TILES:    ctrlRead = NUM_TILES;
      REG_PORTAL_ID:    ctrlRead = port.indication ? INDICATION_PORTAL_ID : REQUEST_PORTAL_ID;
      REG_NUM_PORTALS:  ctrlRead = NUM_PORTALS;
      default:          ctrlRead = UNMAPPED_VALUE;
    endcase
  end

  always_comb begin
    case (port.offset)
      DATA_WORD:  dataRead = pending ? indicationWord : '0;   // Empty reads as 0
      DATA_SPACE: dataRead = {31'd0, requestReady};
      default:    dataRead = '0;
    endcase
  end

  assign portRead = port.control ? ctrlRead : dataRead;

  // Request writes hold the port until the user logic takes the word
  assign requestValid = portValid && port.write && !port.indication && dataWordHit;
  assign requestWord  = port.data;
  assign portReady    = requestValid ? requestReady : 1'b1;

  assign indicationReady = portValid && !port.write && pending && dataWordHit;
  assign interrupt       = indicationValid && intrEnable;

  always_ff @(posedge CLK) begin
    if (!nRST)
      intrEnable <= 1'b0;
    else if (portValid && port.write && port.control && port.offset == REG_INTR_ENABLE)
      intrEnable <= port.data[0];
  end

endmodule

`default_nettype wire

//--- portalTop.sv
`timescale 1ns/1ps
`default_nettype none

module portalTop (
  input  logic                    CLK,
  input  logic                    nRST,
  input  portalBusPkg::burstReq_t arReq,
  input  logic                    arValid,
  output logic                    arReady,
  output portalBusPkg::readResp_t r,
  output logic                    rValid,
  input  logic                    rReady,
  input  portalBusPkg::burstReq_t awReq,
  input  logic                    awValid,
  output logic                    awReady,
  input  portalBusPkg::dataWord_t wData,
  input  logic                    wLast,
  input  logic                    wValid,
  output logic                    wReady,
  output portalBusPkg::txnId_t    bId,
  output logic                    bValid,
  input  logic                    bReady,
  output portalBusPkg::dataWord_t requestWord,
  output logic                    requestValid,
  input  logic                    requestReady,
  input  portalBusPkg::dataWord_t indicationWord,
  input  logic                    indicationValid,
  output logic                    indicationReady,
  output logic                    interrupt
);
  import portalBusPkg::*;

  beat_t     rdBeat, wrBeat, port;
  logic      rdValid, rdReady, wrValid, wrReady;
  logic      portValid, portReady;
  dataWord_t portRead;

  readChannel readCh (
    .CLK, .nRST,
    .arReq, .arValid, .arReady,
    .r, .rValid, .rReady,
    .beat(rdBeat), .beatValid(rdValid), .beatReady(rdReady),
    .regData(portRead)
  );

  writeChannel writeCh (
    .CLK, .nRST,
    .awReq, .awValid, .awReady,
    .wData, .wLast, .wValid, .wReady,
    .bId, .bValid, .bReady,
    .beat(wrBeat), .beatValid(wrValid), .beatReady(wrReady)
  );

  beatArbiter arbiter (
    .CLK, .nRST,
    .rdBeat, .rdValid, .rdReady,
    .wrBeat, .wrValid, .wrReady,
    .port, .portValid, .portReady
  );

  portalRegisters regs (
    .CLK, .nRST,
    .port, .portValid, .portReady, .portRead,
    .requestWord, .requestValid, .requestReady,
    .indicationWord, .indicationValid, .indicationReady,
    .interrupt
  );

endmodule

`default_nettype wire

//--- portalTb.sv
`timescale 1ns/1ps
`default_nettype none

module portalTb;
  import portalBusPkg::*;
  import portalRegPkg::*;

  logic      CLK, nRST;
  burstReq_t arReq, awReq;
  logic      arValid, arReady, awValid, awReady;
  readResp_t r;
  logic      rValid, rReady;
  dataWord_t wData;
  logic      wLast, wValid, wReady;
  txnId_t    bId;
  logic      bValid, bReady;
  dataWord_t requestWord, indicationWord;
  logic      requestValid, requestReady;
  logic      indicationValid, indicationReady, interrupt;

  readResp_t expR [$];
  txnId_t    expB [$];
  dataWord_t expReq [$];
  dataWord_t indQ [$];       // Words still offered to the DUT
  dataWord_t indModel [$];   // Words not yet claimed by a predicted read
  logic      enableModel;
  logic      stall;
  integer    seed = 32'hbdbd_b3f7;
  int        mismatches, otherErrors;
  txnId_t    nextId;

  portalTop dut (.*);

  initial CLK = 1'b0;
  always #50 CLK = !CLK;

  task automatic finishRun();
    $display("errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic giveUp(string what);
    otherErrors++;
    $display("timeout at %0t: %s", $time, what);
    finishRun();
  endtask

  task automatic checkData(string name, dataWord_t got, dataWord_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkId(string name, txnId_t got, txnId_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Register map as seen from the bus
  function automatic dataWord_t expectedRead(logic ind, logic ctrl, portalOffset_t off,
      logic en, logic indValid, dataWord_t indWord, logic reqReady);
    logic pend;
    pend = ind && indValid;
    if (!ctrl)
      return off == DATA_WORD ? (pend ? indWord : '0) :
             off == DATA_SPACE ? {31'd0, reqReady} : '0;
    case (off)
      REG_INTR_STATUS, REG_QUEUE_STATUS: return {31'd0, pend};
      REG_INTR_ENABLE: return {31'd0, en};
      REG_NUM_TILES:   return NUM_TILES;
      REG_PORTAL_ID:   return ind ? INDICATION_PORTAL_ID : REQUEST_PORTAL_ID;
      REG_NUM_PORTALS: return NUM_PORTALS;
      default:         return UNMAPPED_VALUE;
    endcase
  endfunction

  task automatic sendRead(busAddr_t addr, burstLen_t len, txnId_t id);
    portalOffset_t off;
    readResp_t     e;
    logic          indValid;
    logic          done;
    int            i, n;
    off = addr[4:0];
    for (i = 0; i <= int'(len); i++) begin
      indValid = indModel.size() != 0;
      e.data = expectedRead(addr[12], addr[11:5] == 7'd0, off, enableModel, indValid,
                            indValid ? indModel[0] : '0, requestReady);
      e.id   = id;
      e.last = i == int'(len);
      expR.push_back(e);
      if (addr[12] && addr[11:5] != 7'd0 && off == DATA_WORD && indValid)
        void'(indModel.pop_front());   // This beat claims the word
      off = off + 5'd4;
    end
    arReq   = '{addr: addr, len: len, id: id};
    arValid = 1'b1;
    done = 1'b0;
    for (n = 0; n < 200 && !done; n++) begin
      @(posedge CLK);
      done = arReady;
    end
    if (!done)
      giveUp("read address never accepted");
    #10;
    arValid = 1'b0;
  endtask

  task automatic sendWrite(busAddr_t addr, burstLen_t len, txnId_t id, dataWord_t base);
    portalOffset_t off;
    logic          done;
    int            i, n;
    off = addr[4:0];
    for (i = 0; i <= int'(len); i++) begin
      if (!addr[12] && addr[11:5] != 7'd0 && off == DATA_WORD)
        expReq.push_back(base + dataWord_t'(i));
      if (addr[11:5] == 7'd0 && off == REG_INTR_ENABLE)
        enableModel = base[0] ^ i[0];   // Low bit of base plus i
      off = off + 5'd4;
    end
    expB.push_back(id);
    awReq   = '{addr: addr, len: len, id: id};
    awValid = 1'b1;
    done = 1'b0;
    for (n = 0; n < 200 && !done; n++) begin
      @(posedge CLK);
      done = awReady;
    end
    if (!done)
      giveUp("write address never accepted");
    #10;
    awValid = 1'b0;
    for (i = 0; i <= int'(len); i++) begin
      wData  = base + dataWord_t'(i);
      wLast  = i == int'(len);
      wValid = 1'b1;
      done = 1'b0;
      for (n = 0; n < 200 && !done; n++) begin
        @(posedge CLK);
        done = wReady;
      end
      if (!done)
        giveUp("write data never accepted");
      #10;
    end
    wValid = 1'b0;
    wLast  = 1'b0;
  endtask

  task automatic waitIdle();
    int n;
    for (n = 0; n < 3000 && (expR.size() + expB.size() + expReq.size()) != 0; n++) begin
      @(posedge CLK);
      #10;
    end
    if ((expR.size() + expB.size() + expReq.size()) != 0)
      giveUp("outstanding transfers never completed");
  endtask

  task automatic pushIndication(dataWord_t w);
    logic done;
    int   n;
    indQ.push_back(w);
    indModel.push_back(w);
    done = 1'b0;
    for (n = 0; n < 20 && !done; n++) begin
      @(posedge CLK);
      done = indicationValid;
    end
    if (!done)
      giveUp("indication word never offered");
    #10;
  endtask

  task automatic checkInterrupt(logic exp);
    @(posedge CLK);
    checkBit("interrupt", interrupt, exp);
    #10;
  endtask

  // Indication source, pops on the edge where the DUT takes a word
  always @(posedge CLK) begin
    if (nRST && indicationValid && indicationReady)
      void'(indQ.pop_front());
    #10;
    indicationValid = indQ.size() != 0;
    indicationWord  = indicationValid ? indQ[0] : '0;
  end

  always @(posedge CLK) begin
    integer pick;
    pick = $random(seed);
    #10;
    rReady       = !stall || pick[0];
    bReady       = !stall || pick[1];
    requestReady = !stall || pick[2] || pick[3];   // Mostly ready
  end

  always @(posedge CLK) begin
    readResp_t e;
    if (nRST && rValid && rReady) begin
      if (expR.size() == 0) begin
        otherErrors++;
        $display("read beat at %0t was not expected", $time);
      end else begin
        e = expR.pop_front();
        checkData("r.data", r.data, e.data);
        checkId("r.id", r.id, e.id);
        checkBit("r.last", r.last, e.last);
      end
    end
    if (nRST && bValid && bReady) begin
      if (expB.size() == 0) begin
        otherErrors++;
        $display("write response at %0t was not expected", $time);
      end else
        checkId("bId", bId, expB.pop_front());
    end
    if (nRST && requestValid && requestReady) begin
      if (expReq.size() == 0) begin
        otherErrors++;
        $display("request word at %0t was not expected", $time);
      end else
        checkData("requestWord", requestWord, expReq.pop_front());
    end
  end

  initial begin
    int     i;
    integer k;
    nRST = 1'b0;
    arReq = '0;
    arValid = 1'b0;
    awReq = '0;
    awValid = 1'b0;
    wData = '0;
    wLast = 1'b0;
    wValid = 1'b0;
    rReady = 1'b1;
    bReady = 1'b1;
    requestReady = 1'b1;
    indicationWord = '0;
    indicationValid = 1'b0;
    stall = 1'b0;
    enableModel = 1'b0;
    nextId = '0;
    repeat (2) @(posedge CLK);
    #10;
    nRST = 1'b1;
    @(posedge CLK);
    checkBit("arReady", arReady, 1'b1);
    checkBit("awReady", awReady, 1'b1);
    checkBit("wReady", wReady, 1'b1);
    checkBit("rValid", rValid, 1'b0);
    checkBit("bValid", bValid, 1'b0);
    checkBit("requestValid", requestValid, 1'b0);
    checkBit("indicationReady", indicationReady, 1'b0);
    checkBit("interrupt", interrupt, 1'b0);
    #10;

    // Every control offset on both portals, one pending indication
    pushIndication(32'h1111_0001);
    for (i = 0; i < 16; i++) begin
      sendRead({i[3], 7'd0, i[2:0], 2'b00}, 4'd0, nextId);
      nextId++;
    end
    waitIdle();
    checkInterrupt(1'b0);

    sendWrite({1'b0, 7'd0, REG_INTR_ENABLE}, 4'd0, nextId++, 32'd1);
    waitIdle();
    checkInterrupt(1'b1);
    sendRead({1'b1, 7'd0, REG_INTR_ENABLE}, 4'd0, nextId++);

    // Two indication words per 16-beat burst, then empty reads
    pushIndication(32'h1111_0002);
    pushIndication(32'h1111_0003);
    sendRead({1'b1, 7'd1, 5'd0}, 4'd15, nextId++);
    sendRead({1'b1, 7'd1, 5'd0}, 4'd15, nextId++);
    waitIdle();
    checkInterrupt(1'b0);

    sendWrite({1'b1, 7'd0, REG_INTR_ENABLE}, 4'd0, nextId++, 32'd0);
    waitIdle();
    pushIndication(32'h2222_0001);
    checkInterrupt(1'b0);

    sendWrite({1'b0, 7'd1, 5'd0}, 4'd3, nextId++, 32'hA000_0000);
    sendWrite({1'b0, 7'd2, 5'd0}, 4'd15, nextId++, 32'hB000_0000);
    waitIdle();

    // Overlap with a steady requestReady so DATA_SPACE is known
    fork
      sendRead({1'b1, 7'd5, 5'd0}, 4'd3, 6'd60);
      sendWrite({1'b0, 7'd4, 5'd0}, 4'd7, 6'd61, 32'hC000_0000);
    join
    waitIdle();

    stall = 1'b1;
    for (i = 0; i < 10; i++) begin
      k = $random(seed);
      sendWrite({1'b0, 7'd3, k[2:0], 2'b00}, k[6:3], nextId++, dataWord_t'(k));
      sendRead({k[7], 7'd0, k[10:8], 2'b00}, {2'b00, k[12:11]}, nextId++);
    end
    waitIdle();
    for (i = 0; i < 4; i++) begin
      fork
        sendRead({i[0], 7'd0, 5'd8}, 4'd5, nextId);
        sendWrite({1'b0, 7'd6, 5'd0}, 4'd9, nextId + 6'd1, 32'hD000_0000 + i);
      join
      nextId = nextId + 6'd2;
    end
    waitIdle();
    finishRun();
  end

endmodule

`default_nettype wire

//--- sim.f
portalBusPkg.sv
portalRegPkg.sv
burstSplitter.sv
readChannel.sv
writeChannel.sv
beatArbiter.sv
portalRegisters.sv
portalTop.sv
portalTb.sv

//--- Makefile
.PHONY: lint sim clean

LOG = sim.log

lint:
	verilator --lint-only --timing --top-module portalTb -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module portalTb \
		-f sim.f -Mdir obj_dir -o portalSim
	./obj_dir/portalSim | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
